/* Bender.yml */
package:
  name: bilinear_sampler

sources:
  - files:
      - src/texture_pkg.sv
      - src/pixel_if.sv
      - src/tap_address_gen.sv
      - src/texel_accumulator.sv
      - src/pixel_output_stage.sv
      - src/bilinear_sampler.sv
  - target: test
    files:
      - testbench/tb_texture_memory.sv
      - testbench/tb_bilinear_sampler.sv

/* src.f */
src/texture_pkg.sv
src/pixel_if.sv
src/tap_address_gen.sv
src/texel_accumulator.sv
src/pixel_output_stage.sv
src/bilinear_sampler.sv
testbench/tb_texture_memory.sv
testbench/tb_bilinear_sampler.sv

/* src/bilinear_sampler.sv */
// bilinear texture sampler top level, sample in, texel reads out and back, pixel out

`timescale 1ns/1ps

module bilinear_sampler (
    input  logic                clk,
    input  logic                reset,

    input  texture_pkg::texel_t blank_value,

    // sample input
    input  texture_pkg::coord_t s_x,
    input  texture_pkg::coord_t s_y,
    input  logic                s_strb,
    input  logic                s_valid,
    output logic                s_ready,

    // texel read request
    output texture_pkg::addr_t  mem_araddrx,
    output texture_pkg::addr_t  mem_araddry,
    output texture_pkg::coeff_t mem_arcoeff,
    output logic                mem_arstrb,
    output logic                mem_arvalid,
    input  logic                mem_arready,

    // texel read data
    input  texture_pkg::coeff_t mem_rcoeff,
    input  texture_pkg::texel_t mem_rdata,
    input  logic                mem_rstrb,
    input  logic                mem_rvalid,
    output logic                mem_rready,

    // pixel output
    output texture_pkg::texel_t m_data,
    output logic                m_strb,
    output logic                m_valid,
    input  logic                m_ready
);

    pixel_if pix ();

    tap_address_gen i_tap_address_gen (
        .clk         (clk),
        .reset       (reset),
        .s_x         (s_x),
        .s_y         (s_y),
        .s_strb      (s_strb),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .mem_araddrx (mem_araddrx),
        .mem_araddry (mem_araddry),
        .mem_arcoeff (mem_arcoeff),
        .mem_arstrb  (mem_arstrb),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready)
    );

    texel_accumulator i_texel_accumulator (
        .clk         (clk),
        .reset       (reset),
        .mem_rcoeff  (mem_rcoeff),
        .mem_rdata   (mem_rdata),
        .mem_rstrb   (mem_rstrb),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .pix         (pix.source)
    );

    pixel_output_stage i_pixel_output_stage (
        .clk         (clk),
        .reset       (reset),
        .blank_value (blank_value),
        .pix         (pix.sink),
        .m_data      (m_data),
        .m_strb      (m_strb),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule

/* src/pixel_if.sv */
// valid/ready channel carrying one accumulated pixel from the accumulator to the output stage

`timescale 1ns/1ps

interface pixel_if;

    texture_pkg::texel_t data;
    logic                strb;
    logic                valid;
    logic                ready;

    // accumulator side
    modport source (
        output data,
        output strb,
        output valid,
        input  ready
    );

    // output register side
    modport sink (
        input  data,
        input  strb,
        input  valid,
        output ready
    );

endinterface

/* src/pixel_output_stage.sv */
// one-entry output register that substitutes the blank value for strobe-low pixels

`timescale 1ns/1ps

module pixel_output_stage (
    input  logic                clk,
    input  logic                reset,

    input  texture_pkg::texel_t blank_value,

    pixel_if.sink               pix,

    output texture_pkg::texel_t m_data,
    output logic                m_strb,
    output logic                m_valid,
    input  logic                m_ready
);

    logic take;

    // free when empty or draining this cycle
    assign pix.ready = !m_valid || m_ready;
    assign take      = pix.valid && pix.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (take) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_data <= pix.strb ? pix.data : blank_value;
            m_strb <= pix.strb;
        end
    end

    a_output_hold: assert property (
        @(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_strb)
    );

endmodule

/* src/tap_address_gen.sv */
// expands each accepted sample into four texel read requests, each with its bilinear weight

`timescale 1ns/1ps

module tap_address_gen (
    input  logic                clk,
    input  logic                reset,

    input  texture_pkg::coord_t s_x,
    input  texture_pkg::coord_t s_y,
    input  logic                s_strb,
    input  logic                s_valid,
    output logic                s_ready,

    output texture_pkg::addr_t  mem_araddrx,
    output texture_pkg::addr_t  mem_araddry,
    output texture_pkg::coeff_t mem_arcoeff,
    output logic                mem_arstrb,
    output logic                mem_arvalid,
    input  logic                mem_arready
);

    // -------------------------------------------------------------------------
    // sample split
    // -------------------------------------------------------------------------

    texture_pkg::addr_t      x_int;
    texture_pkg::addr_t      y_int;
    texture_pkg::frac_t      x_frac;
    texture_pkg::frac_t      y_frac;

    logic [texture_pkg::FRAC_WIDTH:0] coeffx_sel;
    logic [texture_pkg::FRAC_WIDTH:0] coeffy_sel;

    texture_pkg::tap_phase_e phase;
    logic                    advance;

    assign x_int  = s_x[texture_pkg::FRAC_WIDTH +: texture_pkg::INT_WIDTH];
    assign y_int  = s_y[texture_pkg::FRAC_WIDTH +: texture_pkg::INT_WIDTH];
    assign x_frac = s_x[texture_pkg::FRAC_WIDTH-1:0];
    assign y_frac = s_y[texture_pkg::FRAC_WIDTH-1:0];

    // near tap gets 16 - f, far tap gets f
    assign coeffx_sel = phase[0] ? {1'b0, x_frac} : (5'd16 - {1'b0, x_frac});
    assign coeffy_sel = phase[1] ? {1'b0, y_frac} : (5'd16 - {1'b0, y_frac});

    // whole pipe stalls while a request waits
    assign advance = !mem_arvalid || mem_arready;
    assign s_ready = advance && (phase == texture_pkg::TAP_11);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= texture_pkg::TAP_00;
        end else if (advance && s_valid) begin
            phase <= texture_pkg::tap_phase_e'(phase + 2'd1);
        end
    end

    // -------------------------------------------------------------------------
    // stage 0 and stage 1
    // -------------------------------------------------------------------------

    logic [texture_pkg::FRAC_WIDTH:0] st0_coeffx;
    logic [texture_pkg::FRAC_WIDTH:0] st0_coeffy;
    texture_pkg::addr_t               st0_x;
    texture_pkg::addr_t               st0_y;
    logic                             st0_strb;
    logic                             st0_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
        end else if (advance) begin
            st0_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st0_coeffx <= coeffx_sel;
            st0_coeffy <= coeffy_sel;
            st0_x      <= x_int + texture_pkg::addr_t'(phase[0]);
            st0_y      <= y_int + texture_pkg::addr_t'(phase[1]);
            st0_strb   <= s_strb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_arvalid <= 1'b0;
        end else if (advance) begin
            mem_arvalid <= st0_valid;
        end
    end

    // product of two 5 bit weights, at most 256
    always_ff @(posedge clk) begin
        if (advance) begin
            mem_arcoeff <= st0_coeffx * st0_coeffy;
            mem_araddrx <= st0_x;
            mem_araddry <= st0_y;
            mem_arstrb  <= st0_strb;
        end
    end

    a_request_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddrx)
            && $stable(mem_araddry) && $stable(mem_arcoeff) && $stable(mem_arstrb)
    );

endmodule

/* src/texel_accumulator.sv */
// weights each returned texel and sums four beats into one pixel for the output stage

`timescale 1ns/1ps

module texel_accumulator (
    input  logic                 clk,
    input  logic                 reset,

    input  texture_pkg::coeff_t  mem_rcoeff,
    input  texture_pkg::texel_t  mem_rdata,
    input  logic                 mem_rstrb,
    input  logic                 mem_rvalid,
    output logic                 mem_rready,

    pixel_if.source              pix
);

    // -------------------------------------------------------------------------
    // beat tracking
    // -------------------------------------------------------------------------

    texture_pkg::tap_phase_e beat_phase;
    logic                    beat;
    logic                    first_beat;
    logic                    last_beat;

    logic                    pix_valid;
    logic                    pix_strb;
    texture_pkg::texel_t     pix_data;
    texture_pkg::texel_t     pix_next;

    // accept only while the result register can take a pixel
    assign mem_rready = !pix_valid || pix.ready;
    assign beat       = mem_rvalid && mem_rready;
    assign first_beat = beat_phase == texture_pkg::TAP_00;
    assign last_beat  = beat_phase == texture_pkg::TAP_11;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_phase <= texture_pkg::TAP_00;
        end else if (beat) begin
            beat_phase <= texture_pkg::tap_phase_e'(beat_phase + 2'd1);
        end
    end

    // -------------------------------------------------------------------------
    // per component multiply-accumulate
    // -------------------------------------------------------------------------

    for (genvar k = 0; k < texture_pkg::COMPONENT_NUM; k++) begin : g_comp
        texture_pkg::component_t            comp;
        logic [texture_pkg::ACC_WIDTH-1:0]  prod;
        logic [texture_pkg::ACC_WIDTH-1:0]  sum;
        logic [texture_pkg::ACC_WIDTH-1:0]  acc;

        assign comp = mem_rdata[k*texture_pkg::DATA_WIDTH +: texture_pkg::DATA_WIDTH];
        assign prod = mem_rcoeff * comp;
        assign sum  = acc + prod;

        always_ff @(posedge clk) begin
            if (beat) begin
                acc <= first_beat ? prod : sum;
            end
        end

        // drop the weight fraction
        assign pix_next[k*texture_pkg::DATA_WIDTH +: texture_pkg::DATA_WIDTH] =
            texture_pkg::component_t'(sum >> texture_pkg::COEFF_FRAC_WIDTH);
    end

    // -------------------------------------------------------------------------
    // result register
    // -------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else if (beat && last_beat) begin
            pix_valid <= 1'b1;
        end else if (pix.ready) begin
            pix_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat && last_beat) begin
            pix_data <= pix_next;
            pix_strb <= mem_rstrb;
        end
    end

    assign pix.data  = pix_data;
    assign pix.strb  = pix_strb;
    assign pix.valid = pix_valid;

    a_pixel_hold: assert property (
        @(posedge clk) disable iff (reset)
        pix.valid && !pix.ready |=> pix.valid && $stable(pix.data)
    );

endmodule

/* src/texture_pkg.sv */
// shared widths, fixed-point types and the tap phase encoding for the bilinear sampler

package texture_pkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------

    // texel layout
    localparam int COMPONENT_NUM    = 3;
    localparam int DATA_WIDTH       = 8;

    // coordinate format, same on both axes
    localparam int INT_WIDTH        = 10;
    localparam int FRAC_WIDTH       = 4;

    // one unit of weight is 1 << COEFF_FRAC_WIDTH
    localparam int COEFF_FRAC_WIDTH = 2 * FRAC_WIDTH;
    localparam int COEFF_WIDTH      = COEFF_FRAC_WIDTH + 1;

    // weight times component, four taps never exceed one unit of weight
    localparam int ACC_WIDTH        = COEFF_WIDTH + DATA_WIDTH;

    // -------------------------------------------------------------------------
    // types
    // -------------------------------------------------------------------------

    typedef logic [INT_WIDTH+FRAC_WIDTH-1:0]    coord_t;
    typedef logic [INT_WIDTH-1:0]               addr_t;
    typedef logic [FRAC_WIDTH-1:0]              frac_t;
    typedef logic [COEFF_WIDTH-1:0]             coeff_t;
    typedef logic [DATA_WIDTH-1:0]              component_t;

    // component 0 in the low bits
    typedef logic [COMPONENT_NUM*DATA_WIDTH-1:0] texel_t;

    // bit 0 picks x+1, bit 1 picks y+1
    typedef enum logic [1:0] {
        TAP_00 = 2'b00,
        TAP_01 = 2'b01,
        TAP_10 = 2'b10,
        TAP_11 = 2'b11
    } tap_phase_e;

endpackage

/* testbench/tb_bilinear_sampler.sv */
// bilinear sampler testbench, drives samples and checks read requests and output pixels

`timescale 1ns/1ps

module tb_bilinear_sampler;

    localparam int SAMPLE_NUM     = 48;
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        texture_pkg::addr_t  x;
        texture_pkg::addr_t  y;
        texture_pkg::coeff_t coeff;
        logic                strb;
    } tap_t;

    typedef struct packed {
        texture_pkg::texel_t data;
        logic                strb;
    } pixel_t;

    logic                clk = 1'b0;
    logic                reset;
    texture_pkg::texel_t blank_value;
    texture_pkg::coord_t s_x;
    texture_pkg::coord_t s_y;
    logic                s_strb;
    logic                s_valid;
    logic                s_ready;
    texture_pkg::addr_t  mem_araddrx;
    texture_pkg::addr_t  mem_araddry;
    texture_pkg::coeff_t mem_arcoeff;
    logic                mem_arstrb;
    logic                mem_arvalid;
    logic                mem_arready;
    texture_pkg::coeff_t mem_rcoeff;
    texture_pkg::texel_t mem_rdata;
    logic                mem_rstrb;
    logic                mem_rvalid;
    logic                mem_rready;
    texture_pkg::texel_t m_data;
    logic                m_strb;
    logic                m_valid;
    logic                m_ready  = 1'b0;
    logic                ar_stall = 1'b0;
    logic                r_stall  = 1'b0;

    logic [31:0]         lfsr = 32'hbb839fc9;
    int                  mismatch_count = 0;
    int                  failure_count = 0;
    int                  coeff_sum = 0;
    int                  tap_count = 0;
    tap_t                expected_taps [$];
    pixel_t              expected_pixels [$];
    texture_pkg::coord_t sample_x [SAMPLE_NUM];
    texture_pkg::coord_t sample_y [SAMPLE_NUM];
    logic                sample_strb [SAMPLE_NUM];

    always #5 clk = ~clk;

    bilinear_sampler i_bilinear_sampler (.*);

    tb_texture_memory i_texture_memory (.*);

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    // galois lfsr, one step per bit
    function automatic logic random_bit();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr    = (lfsr >> 1) ^ (bit_out ? 32'h8020_0003 : 32'h0);
        return bit_out;
    endfunction

    function automatic int random_bits(int width);
        int value;
        int i;
        value = 0;
        for (i = 0; i < width; i++) begin
            value = (value << 1) | int'(random_bit());
        end
        return value;
    endfunction

    function automatic int texel_component(int x, int y, int k);
        return (3 * (x % 1024) + 5 * (y % 1024) + 7 * k + 40) % 256;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatch_count++;
        $display("MISMATCH t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    endtask

    // four taps in order 00, 01, 10, 11 and the weighted pixel
    task automatic push_expected(input texture_pkg::coord_t x, input texture_pkg::coord_t y,
                                 input logic strb);
        int     ix;
        int     iy;
        int     sum;
        int     k;
        int     tap;
        int     wx [2];
        int     wy [2];
        tap_t   req;
        pixel_t pix;
        ix    = int'(x[13:4]);
        iy    = int'(y[13:4]);
        wx[0] = 16 - int'(x[3:0]);
        wx[1] = int'(x[3:0]);
        wy[0] = 16 - int'(y[3:0]);
        wy[1] = int'(y[3:0]);
        for (tap = 0; tap < 4; tap++) begin
            req.x     = texture_pkg::addr_t'(ix + tap % 2);
            req.y     = texture_pkg::addr_t'(iy + tap / 2);
            req.coeff = texture_pkg::coeff_t'(wx[tap % 2] * wy[tap / 2]);
            req.strb  = strb;
            expected_taps.push_back(req);
        end
        for (k = 0; k < 3; k++) begin
            sum = 0;
            for (tap = 0; tap < 4; tap++) begin
                sum += wx[tap % 2] * wy[tap / 2]
                    * texel_component(ix + tap % 2, iy + tap / 2, k);
            end
            pix.data[k*8 +: 8] = texture_pkg::component_t'(sum / 256);
        end
        pix.strb = strb;
        if (!strb) begin
            pix.data = blank_value;
        end
        expected_pixels.push_back(pix);
    endtask

    task automatic send_sample(input int index);
        int   waited;
        logic accepted;
        push_expected(sample_x[index], sample_y[index], sample_strb[index]);
        s_x      = sample_x[index];
        s_y      = sample_y[index];
        s_strb   = sample_strb[index];
        s_valid  = 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            accepted = s_ready;
            waited++;
        end
        if (!accepted) begin
            failure_count++;
            $display("ERROR t=%0t sample %0d was never accepted", $time, index);
        end
        #1;
        s_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // stalls, monitors and checks
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        #1;
        m_ready  = random_bit() | random_bit();
        ar_stall = random_bit() & random_bit();
        r_stall  = random_bit() & random_bit();
    end

    always @(posedge clk) begin
        tap_t   req;
        pixel_t pix;
        if (!reset && mem_arvalid && mem_arready) begin
            if (expected_taps.size() == 0) begin
                failure_count++;
                $display("ERROR t=%0t read request with no sample pending", $time);
            end else begin
                req = expected_taps.pop_front();
                assert (mem_araddrx == req.x)
                    else report_mismatch("mem_araddrx", req.x, mem_araddrx);
                assert (mem_araddry == req.y)
                    else report_mismatch("mem_araddry", req.y, mem_araddry);
                assert (mem_arcoeff == req.coeff)
                    else report_mismatch("mem_arcoeff", req.coeff, mem_arcoeff);
                assert (mem_arstrb == req.strb)
                    else report_mismatch("mem_arstrb", req.strb, mem_arstrb);
                coeff_sum += int'(mem_arcoeff);
                tap_count++;
                if (tap_count == 4) begin
                    assert (coeff_sum == 256)
                        else report_mismatch("mem_arcoeff sum", 256, coeff_sum);
                    coeff_sum = 0;
                    tap_count = 0;
                end
            end
        end
        if (!reset && m_valid && m_ready) begin
            if (expected_pixels.size() == 0) begin
                failure_count++;
                $display("ERROR t=%0t pixel came out with no sample pending", $time);
            end else begin
                pix = expected_pixels.pop_front();
                assert (m_data == pix.data) else report_mismatch("m_data", pix.data, m_data);
                assert (m_strb == pix.strb) else report_mismatch("m_strb", pix.strb, m_strb);
            end
        end
    end

    output_hold_check: assert property (
        @(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_strb)
    ) else begin
        failure_count++;
        $display("ERROR t=%0t output pixel changed while m_ready was low", $time);
    end

    // read data may only stall while the output register is full and held
    read_ready_check: assert property (
        @(posedge clk) disable iff (reset)
        !mem_rready |-> m_valid && !m_ready
    ) else begin
        failure_count++;
        $display("ERROR t=%0t mem_rready low while the output register could take a pixel",
                 $time);
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        int i;
        int waited;
        reset       = 1'b1;
        blank_value = 24'h3c_a5_5a;
        s_x         = '0;
        s_y         = '0;
        s_strb      = 1'b0;
        s_valid     = 1'b0;
        for (i = 0; i < SAMPLE_NUM; i++) begin
            sample_x[i] = texture_pkg::coord_t'(random_bits(14));
            sample_y[i] = texture_pkg::coord_t'(random_bits(14));
            // first samples sit on whole texels
            if (i < 8) begin
                sample_x[i][3:0] = '0;
                sample_y[i][3:0] = '0;
            end
            // keep x+1 and y+1 inside the texture
            if (sample_x[i][13:4] == 10'h3ff) begin
                sample_x[i][13] = 1'b0;
            end
            if (sample_y[i][13:4] == 10'h3ff) begin
                sample_y[i][13] = 1'b0;
            end
            sample_strb[i] = (i % 6) != 5;
        end

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!s_ready) else report_mismatch("s_ready", 0, s_ready);
        assert (!mem_arvalid) else report_mismatch("mem_arvalid", 0, mem_arvalid);
        assert (!m_valid) else report_mismatch("m_valid", 0, m_valid);
        assert (mem_rready) else report_mismatch("mem_rready", 1, mem_rready);

        for (i = 0; i < SAMPLE_NUM; i++) begin
            send_sample(i);
        end

        waited = 0;
        while ((expected_pixels.size() != 0 || expected_taps.size() != 0)
               && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (expected_pixels.size() != 0 || expected_taps.size() != 0) begin
            failure_count++;
            $display("ERROR t=%0t timed out with %0d pixels still expected", $time,
                     expected_pixels.size());
        end
        // idle a little so a stray extra pixel is caught
        repeat (10) @(posedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/tb_texture_memory.sv */
// behavioural texture memory for the sampler testbench, answers read requests in order with stalls

`timescale 1ns/1ps

module tb_texture_memory (
    input  logic                clk,
    input  logic                reset,

    // random stall bits from the testbench
    input  logic                ar_stall,
    input  logic                r_stall,

    input  texture_pkg::addr_t  mem_araddrx,
    input  texture_pkg::addr_t  mem_araddry,
    input  texture_pkg::coeff_t mem_arcoeff,
    input  logic                mem_arstrb,
    input  logic                mem_arvalid,
    output logic                mem_arready,

    output texture_pkg::coeff_t mem_rcoeff,
    output texture_pkg::texel_t mem_rdata,
    output logic                mem_rstrb,
    output logic                mem_rvalid,
    input  logic                mem_rready
);

    localparam int DEPTH = 4;

    typedef struct packed {
        texture_pkg::addr_t  x;
        texture_pkg::addr_t  y;
        texture_pkg::coeff_t coeff;
        logic                strb;
    } request_t;

    request_t pending [$];

    // component k = 3x + 5y + 7k + 40, wrapped to 8 bits
    function automatic texture_pkg::texel_t texel_at(texture_pkg::addr_t x, texture_pkg::addr_t y);
        texture_pkg::texel_t texel;
        for (int k = 0; k < texture_pkg::COMPONENT_NUM; k++) begin
            texel[k*8 +: 8] = texture_pkg::component_t'((3 * x + 5 * y + 7 * k + 40) % 256);
        end
        return texel;
    endfunction

    initial begin
        request_t req;
        request_t head;
        logic     in_reset;
        logic     hold_ar;
        logic     free;
        logic     load;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rcoeff  = '0;
        mem_rdata   = '0;
        mem_rstrb   = 1'b0;
        forever begin
            // sample everything on the edge, drive 1 ns later
            @(posedge clk);
            in_reset = reset;
            hold_ar  = ar_stall;
            free     = !mem_rvalid || mem_rready;
            load     = 1'b0;
            if (in_reset) begin
                pending.delete();
            end else begin
                if (mem_arvalid && mem_arready) begin
                    req.x     = mem_araddrx;
                    req.y     = mem_araddry;
                    req.coeff = mem_arcoeff;
                    req.strb  = mem_arstrb;
                    pending.push_back(req);
                end
                if (free && !r_stall && pending.size() > 0) begin
                    head = pending.pop_front();
                    load = 1'b1;
                end
            end
            #1;
            mem_arready = !in_reset && !hold_ar && pending.size() < DEPTH;
            if (load) begin
                mem_rvalid = 1'b1;
                mem_rdata  = texel_at(head.x, head.y);
                mem_rcoeff = head.coeff;
                mem_rstrb  = head.strb;
            end else if (free || in_reset) begin
                mem_rvalid = 1'b0;
            end
        end
    end

endmodule
